// ==== build.f ====
src/isaPkg.sv
src/ctrlPkg.sv
src/ctrlIf.sv
src/opcodeDecoder.sv
src/stateSequencer.sv
src/controlWordGen.sv
src/controlUnit.sv
test/tbControlUnit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tbControlUnit -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/VtbControlUnit > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== test/tbControlUnit.sv ====
`timescale 1ns/1ps

module tbControlUnit;
	import isaPkg::*;
	import ctrlPkg::*;

	localparam int clkPeriod = 8;
	localparam int maxInstr = 64;
	localparam int cyclesPerInstr = 10;
	localparam opcodeT opUnknown = 6'h3f;

	logic clk;
	logic reset;
	opcodeT opcode;
	functT funct;
	shamtT shamt;
	logic lessThan;
	logic pcWrite;
	logic pcCond;
	pcSourceT pcSource;
	logic branchOnEqual;
	logic irWrite;
	logic memWrite;
	logic addrFromAlu;
	logic mdrLoad;
	logic regWrite;
	regDstT regDst;
	memToRegT memToReg;
	logic writeA;
	logic writeB;
	logic aluSrcA;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	logic aluOutLoad;
	shiftOpT shiftOp;
	logic shiftByReg;
	logic [5:0] debugState;

	controlUnit u_dut (.*);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic stopRun();
		$display("*** FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string name, input string expStr, input string actStr);
		$display("FAILED at %0t ns: %s expected %s, actual %s", $time, name, expStr, actStr);
		stopRun();
	endtask

	task automatic checkState(input ctrlStateT exp);
		ctrlStateT act;
		act = ctrlStateT'(debugState);
		if (debugState !== exp)
			reportMismatch("debugState", exp.name(), $sformatf("%s (%0d)", act.name(), debugState));
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
			reportMismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
	endtask

	task automatic checkPcSource(input pcSourceT exp);
		if (pcSource !== exp)
			reportMismatch("pcSource", $sformatf("%0d", exp), $sformatf("%0d", pcSource));
	endtask

	task automatic checkMemToReg(input memToRegT exp);
		if (memToReg !== exp)
			reportMismatch("memToReg", $sformatf("%0d", exp), $sformatf("%0d", memToReg));
	endtask

	task automatic checkAluOp(input aluOpT exp);
		if (aluOp !== exp)
			reportMismatch("aluOp", $sformatf("%0d", exp), $sformatf("%0d", aluOp));
	endtask

	task automatic checkAluSrcB(input aluSrcBT exp);
		if (aluSrcB !== exp)
			reportMismatch("aluSrcB", $sformatf("%0d", exp), $sformatf("%0d", aluSrcB));
	endtask

	task automatic checkShiftOp(input shiftOpT exp);
		if (shiftOp !== exp)
			reportMismatch("shiftOp", $sformatf("%0d", exp), $sformatf("%0d", shiftOp));
	endtask

	task automatic checkRegDst(input regDstT exp);
		if (regDst !== exp)
			reportMismatch("regDst", $sformatf("%0d", exp), $sformatf("%0d", regDst));
	endtask

	task automatic holdReset();
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	endtask

	// outputs are sampled mid cycle
	task automatic stepTo(input ctrlStateT exp);
		@(negedge clk);
		checkState(exp);
	endtask

	// starts in stMemRead, ends in stDecode
	task automatic fetchInstr(input opcodeT op, input functT fn, input shamtT sh, input logic lt);
		checkState(stMemRead);
		@(posedge clk);
		opcode <= op;
		funct <= fn;
		shamt <= sh;
		lessThan <= lt;
		stepTo(stMemWait);
		stepTo(stIrWrite);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(psAluResult);
		checkAluSrcB(sbFour); // pc + 4
		stepTo(stDecode);
	endtask

	task automatic testReset();
		@(negedge clk);
		checkState(stReset);
		checkBit("irWrite", 1'b1, irWrite);
		checkBit("writeA", 1'b1, writeA);
		checkBit("writeB", 1'b1, writeB);
		checkBit("addrFromAlu", 1'b1, addrFromAlu);
		checkBit("aluSrcA", 1'b1, aluSrcA);
		checkBit("pcWrite", 1'b0, pcWrite);
		checkBit("pcCond", 1'b0, pcCond);
		checkBit("memWrite", 1'b0, memWrite);
		checkBit("mdrLoad", 1'b0, mdrLoad);
		checkBit("regWrite", 1'b0, regWrite);
		checkBit("aluOutLoad", 1'b0, aluOutLoad);
		stepTo(stMemRead);
		fetchInstr(opRType, fnSll, '0, 1'b0);
		stepTo(stNop);
		stepTo(stMemRead);
	endtask

	task automatic testAluOps();
		functT fnList[6];
		ctrlStateT stList[6];
		aluOpT opList[6];
		int order[6];
		int j;
		int tmp;
		fnList = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnXor};
		stList = '{stAdd, stAddu, stSub, stSubu, stAnd, stXor};
		opList = '{aluAdd, aluAdd, aluSub, aluSub, aluAnd, aluXor};
		order = '{0, 1, 2, 3, 4, 5};
		for (int i = 5; i > 0; i--)
		begin
			j = int'($urandom % (i + 1)); // shuffle
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		foreach (order[k])
		begin
			fetchInstr(opRType, fnList[order[k]], '0, 1'b0);
			stepTo(stList[order[k]]);
			checkAluOp(opList[order[k]]);
			stepTo(stAluWrite);
			checkBit("regWrite", 1'b1, regWrite);
			checkRegDst(rdRd);
			stepTo(stMemRead); // 6 cycles per instruction
		end
	endtask

	task automatic sltOnce(input logic lt);
		fetchInstr(opRType, fnSlt, '0, lt);
		stepTo(stSlt);
		checkAluOp(aluCompare);
		stepTo(stSltWrite);
		checkBit("regWrite", 1'b1, regWrite);
		checkRegDst(rdRd);
		checkMemToReg(lt ? wbOne : wbZero);
		stepTo(stMemRead);
	endtask

	task automatic testSlt();
		logic first;
		first = ($urandom % 2) != 0;
		sltOnce(first);
		sltOnce(!first);
	endtask

	task automatic testShifts();
		functT fnList[5];
		ctrlStateT stList[5];
		shiftOpT opList[5];
		shamtT sh;
		logic byReg;
		fnList = '{fnSll, fnSllv, fnSra, fnSrav, fnSrl};
		stList = '{stSll, stSllv, stSra, stSrav, stSrl};
		opList = '{shLeft, shLeft, shRightArith, shRightArith, shRightLogic};
		for (int i = 0; i < 5; i++)
		begin
			byReg = (fnList[i] == fnSllv) || (fnList[i] == fnSrav);
			sh = byReg ? '0 : shamtT'(1 + $urandom % 31); // fixed shifts need shamt > 0
			fetchInstr(opRType, fnList[i], sh, 1'b0);
			stepTo(stShiftLoad);
			checkShiftOp(shLoad);
			stepTo(stList[i]);
			checkBit("regWrite", 1'b1, regWrite);
			checkMemToReg(wbShifter);
			checkShiftOp(opList[i]);
			checkBit("shiftByReg", byReg, shiftByReg);
			stepTo(stMemRead);
		end
		fetchInstr(opRType, fnSll, '0, 1'b0); // sll by zero
		stepTo(stNop);
		stepTo(stMemRead);
	endtask

	task automatic branchOnce(input opcodeT op, input ctrlStateT st, input logic onEqual);
		fetchInstr(op, '0, '0, 1'b0);
		stepTo(st);
		checkBit("pcCond", 1'b1, pcCond);
		checkPcSource(psAluOut);
		checkAluOp(aluSub);
		checkBit("branchOnEqual", onEqual, branchOnEqual);
		stepTo(stMemRead);
	endtask

	task automatic testMemBranch();
		fetchInstr(opLw, '0, '0, 1'b0);
		stepTo(stLwAddr);
		checkAluSrcB(sbImm); // base plus offset
		stepTo(stLwRead);
		stepTo(stLwWait);
		stepTo(stLwLatch);
		checkBit("mdrLoad", 1'b1, mdrLoad);
		stepTo(stLwWrite);
		checkBit("regWrite", 1'b1, regWrite);
		checkMemToReg(wbMemData);
		stepTo(stMemRead);
		fetchInstr(opSw, '0, '0, 1'b0);
		checkBit("memWrite", 1'b0, memWrite);
		stepTo(stSwAddr);
		checkBit("memWrite", 1'b0, memWrite);
		checkAluSrcB(sbImm);
		stepTo(stSwWrite);
		checkBit("memWrite", 1'b1, memWrite);
		stepTo(stSwWait);
		checkBit("memWrite", 1'b1, memWrite);
		stepTo(stMemRead);
		checkBit("memWrite", 1'b0, memWrite);
		branchOnce(opBeq, stBeq, 1'b1);
		branchOnce(opBne, stBne, 1'b0);
		fetchInstr(opLui, '0, '0, 1'b0);
		stepTo(stLui);
		checkBit("regWrite", 1'b1, regWrite);
		checkMemToReg(wbUpperImm);
		stepTo(stMemRead);
	endtask

	task automatic testJumps();
		fetchInstr(opUnknown, '0, '0, 1'b0);
		stepTo(stNop);
		stepTo(stMemRead);
		fetchInstr(opJ, '0, '0, 1'b0);
		stepTo(stJ);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(psJumpTarget);
		stepTo(stMemRead);
		fetchInstr(opRType, fnJr, '0, 1'b0);
		stepTo(stJr);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(psRegA);
		stepTo(stMemRead);
		fetchInstr(opJal, '0, '0, 1'b0);
		stepTo(stJalLink);
		checkBit("regWrite", 1'b1, regWrite);
		checkRegDst(rdRa);
		checkMemToReg(wbPcLink);
		stepTo(stJal);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(psJumpTarget);
		stepTo(stMemRead);
		fetchInstr(opRType, fnBreak, '0, 1'b0);
		stepTo(stBreak);
		repeat (20) stepTo(stBreak); // halted
		@(posedge clk);
		holdReset();
		stepTo(stReset);
		stepTo(stMemRead);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		shamt = '0;
		lessThan = 1'b0;
		void'($urandom(32'he366));
		holdReset();
		testReset();
		testAluOps();
		testSlt();
		testShifts();
		testMemBranch();
		testJumps();
		$display("*** PASSED ***");
		$finish;
	end

	// watchdog
	initial
	begin
		#(maxInstr * cyclesPerInstr * clkPeriod);
		$display("timeout: the tests did not reach the end in time");
		stopRun();
	end

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
(
	input logic clk,
	input logic reset,
	input logic [5:0] opcode,
	input logic [5:0] funct,
	input logic [4:0] shamt,
	input logic lessThan,
	output logic pcWrite,
	output logic pcCond,
	output logic [1:0] pcSource,
	output logic branchOnEqual,
	output logic irWrite,
	output logic memWrite,
	output logic addrFromAlu,
	output logic mdrLoad,
	output logic regWrite,
	output logic [1:0] regDst,
	output logic [2:0] memToReg,
	output logic writeA,
	output logic writeB,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [2:0] aluOp,
	output logic aluOutLoad,
	output logic [2:0] shiftOp,
	output logic shiftByReg,
	output logic [5:0] debugState
);
	import isaPkg::*;
	import ctrlPkg::*;

	instrClassT instrClass;
	shiftKindT shiftKind;
	ctrlStateT state;

	pcMemCtrlIf pcMemBus ();
	regAluCtrlIf regAluBus ();

	opcodeDecoder u_decoder (.opcode(opcode), .funct(funct), .shamt(shamt),
		.instrClass(instrClass), .shiftKind(shiftKind));

	stateSequencer u_sequencer (.clk(clk), .reset(reset), .instrClass(instrClass),
		.shiftKind(shiftKind), .state(state));

	controlWordGen u_wordGen (.state(state), .lessThan(lessThan), .pcMem(pcMemBus.source),
		.regAlu(regAluBus.source));

	assign pcWrite = pcMemBus.pcWrite;
	assign pcCond = pcMemBus.pcCond;
	assign pcSource = pcMemBus.pcSource;
	assign branchOnEqual = pcMemBus.branchOnEqual;
	assign irWrite = pcMemBus.irWrite;
	assign memWrite = pcMemBus.memWrite;
	assign addrFromAlu = pcMemBus.addrFromAlu;
	assign mdrLoad = pcMemBus.mdrLoad;

	assign regWrite = regAluBus.regWrite;
	assign regDst = regAluBus.regDst;
	assign memToReg = regAluBus.memToReg;
	assign writeA = regAluBus.writeA;
	assign writeB = regAluBus.writeB;
	assign aluSrcA = regAluBus.aluSrcA;
	assign aluSrcB = regAluBus.aluSrcB;
	assign aluOp = regAluBus.aluOp;
	assign aluOutLoad = regAluBus.aluOutLoad;
	assign shiftOp = regAluBus.shiftOp;
	assign shiftByReg = regAluBus.shiftByReg;

	assign debugState = state;

endmodule

// ==== src/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen
(
	input ctrlPkg::ctrlStateT state,
	input logic lessThan,
	pcMemCtrlIf.source pcMem,
	regAluCtrlIf.source regAlu
);
	import ctrlPkg::*;

	always_comb
	begin
		pcMem.pcWrite = 1'b0;
		pcMem.pcCond = 1'b0;
		pcMem.pcSource = psAluResult;
		pcMem.branchOnEqual = 1'b0;
		pcMem.irWrite = 1'b0;
		pcMem.memWrite = 1'b0;
		pcMem.addrFromAlu = 1'b0;
		pcMem.mdrLoad = 1'b0;
		regAlu.regWrite = 1'b0;
		regAlu.regDst = rdRt;
		regAlu.memToReg = wbAluOut;
		regAlu.writeA = 1'b0;
		regAlu.writeB = 1'b0;
		regAlu.aluSrcA = 1'b0;
		regAlu.aluSrcB = sbRegB;
		regAlu.aluOp = aluPass;
		regAlu.aluOutLoad = 1'b0;
		regAlu.shiftOp = shNone;
		regAlu.shiftByReg = 1'b0;

		case (state)
			stReset:
			begin
				pcMem.irWrite = 1'b1;
				pcMem.addrFromAlu = 1'b1;
				regAlu.writeA = 1'b1;
				regAlu.writeB = 1'b1;
				regAlu.aluSrcA = 1'b1;
			end
			stMemRead, stMemWait, stIrWrite:
			begin
				pcMem.irWrite = 1'b1;
				pcMem.pcWrite = (state == stIrWrite); // pc + 4 on the last fetch cycle
				regAlu.writeA = 1'b1;
				regAlu.writeB = 1'b1;
				regAlu.aluSrcB = sbFour;
				regAlu.aluOp = aluAdd;
			end
			stDecode:
			begin
				regAlu.writeA = 1'b1;
				regAlu.writeB = 1'b1;
				regAlu.aluSrcB = sbImmShifted; // branch target into aluOut
				regAlu.aluOp = aluAdd;
				regAlu.aluOutLoad = 1'b1;
			end
			stAdd, stAddu, stSub, stSubu, stAnd, stXor:
			begin
				regAlu.aluSrcA = 1'b1;
				regAlu.aluOutLoad = 1'b1;
				case (state)
					stSub, stSubu: regAlu.aluOp = aluSub;
					stAnd: regAlu.aluOp = aluAnd;
					stXor: regAlu.aluOp = aluXor;
					default: regAlu.aluOp = aluAdd;
				endcase
			end
			stAluWrite, stSltWrite:
			begin
				regAlu.regWrite = 1'b1;
				regAlu.regDst = rdRd;
				if (state == stSltWrite)
					regAlu.memToReg = lessThan ? wbOne : wbZero;
			end
			stSlt:
			begin
				regAlu.aluSrcA = 1'b1;
				regAlu.aluOp = aluCompare;
			end
			stBeq, stBne:
			begin
				pcMem.pcCond = 1'b1;
				pcMem.pcSource = psAluOut;
				pcMem.branchOnEqual = (state == stBeq);
				regAlu.aluSrcA = 1'b1;
				regAlu.aluOp = aluSub;
			end
			stLwAddr, stSwAddr:
			begin
				pcMem.addrFromAlu = 1'b1;
				regAlu.aluSrcA = 1'b1;
				regAlu.aluSrcB = sbImm;
				regAlu.aluOp = aluAdd;
				regAlu.aluOutLoad = 1'b1;
			end
			stLwRead, stLwWait: pcMem.addrFromAlu = 1'b1;
			stLwLatch:
			begin
				pcMem.addrFromAlu = 1'b1;
				pcMem.mdrLoad = 1'b1;
			end
			stLwWrite:
			begin
				regAlu.regWrite = 1'b1;
				regAlu.memToReg = wbMemData;
			end
			stSwWrite, stSwWait:
			begin
				pcMem.addrFromAlu = 1'b1;
				pcMem.memWrite = 1'b1; // held over two cycles
			end
			stLui:
			begin
				regAlu.regWrite = 1'b1;
				regAlu.memToReg = wbUpperImm;
			end
			stJ, stJal:
			begin
				pcMem.pcWrite = 1'b1;
				pcMem.pcSource = psJumpTarget;
			end
			stJr:
			begin
				pcMem.pcWrite = 1'b1;
				pcMem.pcSource = psRegA;
			end
			stJalLink:
			begin
				regAlu.regWrite = 1'b1;
				regAlu.regDst = rdRa;
				regAlu.memToReg = wbPcLink;
			end
			stShiftLoad: regAlu.shiftOp = shLoad;
			stSll, stSllv, stSra, stSrav, stSrl:
			begin
				regAlu.regWrite = 1'b1;
				regAlu.regDst = rdRd;
				regAlu.memToReg = wbShifter;
				regAlu.shiftByReg = (state == stSllv) || (state == stSrav); // amount from rs
				case (state)
					stSrl: regAlu.shiftOp = shRightLogic;
					stSra, stSrav: regAlu.shiftOp = shRightArith;
					default: regAlu.shiftOp = shLeft;
				endcase
			end
			default: ; // break and nop stay idle
		endcase

		// a store and a register write never share a cycle
		noWriteClash: assert (!(pcMem.memWrite && regAlu.regWrite))
			else $error("memWrite and regWrite both set");
		// conditional and unconditional pc loads are exclusive
		noPcClash: assert (!(pcMem.pcCond && pcMem.pcWrite))
			else $error("pcCond and pcWrite both set");
	end

endmodule

// ==== src/stateSequencer.sv ====
`timescale 1ns/1ps

module stateSequencer
(
	input logic clk,
	input logic reset,
	input isaPkg::instrClassT instrClass,
	input isaPkg::shiftKindT shiftKind,
	output ctrlPkg::ctrlStateT state
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= stReset;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = stMemRead; // last execute state goes back to fetch
		case (state)
			stMemRead: nextState = stMemWait;
			stMemWait: nextState = stIrWrite;
			stIrWrite: nextState = stDecode;
			stDecode:
			begin
				case (instrClass)
					icAdd: nextState = stAdd;
					icAddu: nextState = stAddu;
					icSub: nextState = stSub;
					icSubu: nextState = stSubu;
					icAnd: nextState = stAnd;
					icXor: nextState = stXor;
					icSlt: nextState = stSlt;
					icShift: nextState = stShiftLoad;
					icJr: nextState = stJr;
					icBreak: nextState = stBreak;
					icBeq: nextState = stBeq;
					icBne: nextState = stBne;
					icLw: nextState = stLwAddr;
					icSw: nextState = stSwAddr;
					icLui: nextState = stLui;
					icJ: nextState = stJ;
					icJal: nextState = stJalLink;
					default: nextState = stNop;
				endcase
			end
			stAdd, stAddu, stSub, stSubu, stAnd, stXor: nextState = stAluWrite;
			stSlt: nextState = stSltWrite;
			stShiftLoad:
			begin
				case (shiftKind)
					skSllv: nextState = stSllv;
					skSra: nextState = stSra;
					skSrav: nextState = stSrav;
					skSrl: nextState = stSrl;
					default: nextState = stSll;
				endcase
			end
			stLwAddr: nextState = stLwRead;
			stLwRead: nextState = stLwWait;
			stLwWait: nextState = stLwLatch;
			stLwLatch: nextState = stLwWrite;
			stSwAddr: nextState = stSwWrite;
			stSwWrite: nextState = stSwWait;
			stJalLink: nextState = stJal;
			stBreak: nextState = stBreak; // halt until reset
			default: nextState = stMemRead;
		endcase
	end

	stateKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(state))
		else $error("state is unknown");

	breakHolds: assert property (@(posedge clk) disable iff (reset)
		state == stBreak |=> state == stBreak)
		else $error("left stBreak without reset");

endmodule

// ==== src/opcodeDecoder.sv ====
`timescale 1ns/1ps

module opcodeDecoder
(
	input isaPkg::opcodeT opcode,
	input isaPkg::functT funct,
	input isaPkg::shamtT shamt,
	output isaPkg::instrClassT instrClass,
	output isaPkg::shiftKindT shiftKind
);
	import isaPkg::*;

	always_comb
	begin
		case (opcode)
			opRType:
			begin
				case (funct)
					fnAdd: instrClass = icAdd;
					fnAddu: instrClass = icAddu;
					fnSub: instrClass = icSub;
					fnSubu: instrClass = icSubu;
					fnAnd: instrClass = icAnd;
					fnXor: instrClass = icXor;
					fnSlt: instrClass = icSlt;
					fnJr: instrClass = icJr;
					fnBreak: instrClass = icBreak;
					fnSll: instrClass = (shamt == '0) ? icNop : icShift; // sll 0 is the nop
					fnSllv, fnSra, fnSrav, fnSrl: instrClass = icShift;
					default: instrClass = icNop;
				endcase
			end
			opBeq: instrClass = icBeq;
			opBne: instrClass = icBne;
			opLw: instrClass = icLw;
			opSw: instrClass = icSw;
			opLui: instrClass = icLui;
			opJ: instrClass = icJ;
			opJal: instrClass = icJal;
			default: instrClass = icNop; // unknown opcode
		endcase
	end

	always_comb
	begin
		case (funct)
			fnSllv: shiftKind = skSllv;
			fnSra: shiftKind = skSra;
			fnSrav: shiftKind = skSrav;
			fnSrl: shiftKind = skSrl;
			default: shiftKind = skSll;
		endcase
	end

endmodule

// ==== src/ctrlIf.sv ====
`timescale 1ns/1ps

// pc, instruction register and memory side
interface pcMemCtrlIf;
	import ctrlPkg::*;

	logic pcWrite;
	logic pcCond;
	pcSourceT pcSource;
	logic branchOnEqual;
	logic irWrite;
	logic memWrite;
	logic addrFromAlu; // memory address from aluOut instead of pc
	logic mdrLoad;

	modport source (output pcWrite, pcCond, pcSource, branchOnEqual, irWrite, memWrite,
		addrFromAlu, mdrLoad);
	modport sink (input pcWrite, pcCond, pcSource, branchOnEqual, irWrite, memWrite,
		addrFromAlu, mdrLoad);
endinterface

// register file, alu and shifter side
interface regAluCtrlIf;
	import ctrlPkg::*;

	logic regWrite;
	regDstT regDst;
	memToRegT memToReg;
	logic writeA;
	logic writeB;
	logic aluSrcA; // 0 pc, 1 reg A
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	logic aluOutLoad;
	shiftOpT shiftOp;
	logic shiftByReg;

	modport source (output regWrite, regDst, memToReg, writeA, writeB, aluSrcA, aluSrcB,
		aluOp, aluOutLoad, shiftOp, shiftByReg);
	modport sink (input regWrite, regDst, memToReg, writeA, writeB, aluSrcA, aluSrcB,
		aluOp, aluOutLoad, shiftOp, shiftByReg);
endinterface

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

	typedef enum logic [5:0] {
		stReset, stMemRead, stMemWait, stIrWrite, stDecode,
		stAdd, stAddu, stSub, stSubu, stAnd, stXor, stAluWrite,
		stBreak, stNop,
		stBeq, stBne,
		stLwAddr, stLwRead, stLwWait, stLwLatch, stLwWrite,
		stSwAddr, stSwWrite, stSwWait,
		stLui, stJ, stJr, stJalLink, stJal,
		stShiftLoad, stSll, stSllv, stSra, stSrav, stSrl,
		stSlt, stSltWrite
	} ctrlStateT;

	// next pc select
	typedef logic [1:0] pcSourceT;
	localparam pcSourceT psAluResult = 2'd0;
	localparam pcSourceT psAluOut = 2'd1; // branch target from decode
	localparam pcSourceT psJumpTarget = 2'd2;
	localparam pcSourceT psRegA = 2'd3;

	// register file write data
	typedef logic [2:0] memToRegT;
	localparam memToRegT wbAluOut = 3'd0;
	localparam memToRegT wbMemData = 3'd1;
	localparam memToRegT wbUpperImm = 3'd2;
	localparam memToRegT wbZero = 3'd3;
	localparam memToRegT wbOne = 3'd4;
	localparam memToRegT wbShifter = 3'd5;
	localparam memToRegT wbPcLink = 3'd6;

	typedef logic [2:0] aluOpT;
	localparam aluOpT aluPass = 3'd0;
	localparam aluOpT aluAdd = 3'd1;
	localparam aluOpT aluSub = 3'd2;
	localparam aluOpT aluAnd = 3'd3;
	localparam aluOpT aluXor = 3'd6;
	localparam aluOpT aluCompare = 3'd7;

	typedef logic [2:0] shiftOpT;
	localparam shiftOpT shNone = 3'd0;
	localparam shiftOpT shLoad = 3'd1;
	localparam shiftOpT shLeft = 3'd2;
	localparam shiftOpT shRightLogic = 3'd3;
	localparam shiftOpT shRightArith = 3'd4;

	typedef logic [1:0] regDstT;
	localparam regDstT rdRt = 2'd0;
	localparam regDstT rdRd = 2'd1;
	localparam regDstT rdRa = 2'd2; // r31 for jal

	typedef logic [1:0] aluSrcBT;
	localparam aluSrcBT sbRegB = 2'd0;
	localparam aluSrcBT sbFour = 2'd1;
	localparam aluSrcBT sbImm = 2'd2;
	localparam aluSrcBT sbImmShifted = 2'd3;

endpackage

// ==== src/isaPkg.sv ====
package isaPkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [4:0] shamtT;

	localparam opcodeT opRType = 6'h00;
	localparam opcodeT opJ = 6'h02;
	localparam opcodeT opJal = 6'h03;
	localparam opcodeT opBeq = 6'h04;
	localparam opcodeT opBne = 6'h05;
	localparam opcodeT opLui = 6'h0f;
	localparam opcodeT opLw = 6'h23;
	localparam opcodeT opSw = 6'h2b;

	localparam functT fnSll = 6'h00; // also nop when shamt is zero
	localparam functT fnSrl = 6'h02;
	localparam functT fnSra = 6'h03;
	localparam functT fnSllv = 6'h04;
	localparam functT fnSrav = 6'h07;
	localparam functT fnJr = 6'h08;
	localparam functT fnBreak = 6'h0d;
	localparam functT fnAdd = 6'h20;
	localparam functT fnAddu = 6'h21;
	localparam functT fnSub = 6'h22;
	localparam functT fnSubu = 6'h23;
	localparam functT fnAnd = 6'h24;
	localparam functT fnXor = 6'h26;
	localparam functT fnSlt = 6'h2a;

	typedef enum logic [4:0] {
		icAdd, icAddu, icSub, icSubu, icAnd, icXor, icSlt, icShift, icNop,
		icJr, icBreak, icBeq, icBne, icLw, icSw, icLui, icJ, icJal
	} instrClassT;

	typedef enum logic [2:0] {skSll, skSllv, skSra, skSrav, skSrl} shiftKindT;

endpackage
